// ==== include/ps2_display_macros.svh ====
`ifndef PS2_DISPLAY_MACROS_SVH
`define PS2_DISPLAY_MACROS_SVH

// --------------------
// PS/2 bit sampling
// --------------------

`define PS2_SAMPLE_COUNT 16   // Data samples per PS/2 bit
`define PS2_SAMPLE_STEP  2    // System clocks between samples

// Received byte width
`define PS2_BYTE_W 8

// --------------------
// Display
// --------------------

`define DISP_DIGITS 3         // Hundreds, tens, ones
`define DISP_BASE   10        // Decimal display

// Active low, every segment dark
`define SEG_BLANK 7'h7F

`endif

// ==== hdl/ps2_display_pkg.sv ====
`include "ps2_display_macros.svh"

package ps2_display_pkg;

  // --------------------
  // Scalar words
  // --------------------

  typedef logic [`PS2_BYTE_W-1:0] ps2_byte_t;  // One received byte
  typedef logic [3:0]             digit_t;     // One digit, 0 to 9 in use
  // Active low, bit 0 top, 1..5 clockwise, bit 6 middle
  typedef logic [6:0]             seg_t;

  // --------------------
  // Structs
  // --------------------

  // One voted PS/2 bit
  typedef struct packed {
    logic valid;  // Single-cycle strobe
    logic value;  // Majority result
  } ps2_bit_t;

  // Output of one radix stage
  typedef struct packed {
    ps2_byte_t quotient;   // Goes to next stage
    digit_t    remainder;  // This stage's digit
  } digit_stage_t;

  // --------------------
  // Vectors, index 0 is the ones digit
  // --------------------

  typedef digit_t [`DISP_DIGITS-1:0] digit_vec_t;
  typedef seg_t   [`DISP_DIGITS-1:0] seg_vec_t;

endpackage

// ==== hdl/ps2_bit_sampler.sv ====
`timescale 1ns/1ps
`include "ps2_display_macros.svh"

module ps2_bit_sampler
  import ps2_display_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     ps2_clk,
  input  logic     ps2_data,
  output ps2_bit_t bit_out
);

  localparam int SAMPLE_COUNT = `PS2_SAMPLE_COUNT;
  localparam int SAMPLE_STEP  = `PS2_SAMPLE_STEP;
  localparam int CNT_W        = $clog2(SAMPLE_COUNT);
  localparam int ONES_W       = $clog2(SAMPLE_COUNT + 1);  // Must hold the full count
  localparam int STEP_W       = (SAMPLE_STEP > 1) ? $clog2(SAMPLE_STEP) : 1;

  logic              clk_meta, clk_sync, clk_prev;  // PS/2 clock sync chain
  logic              data_meta, data_sync;          // PS/2 data sync chain
  logic              clk_fall;
  logic              busy;                          // Sampling window open
  logic [STEP_W-1:0] step_cnt;
  logic [CNT_W-1:0]  sample_cnt;
  logic [ONES_W-1:0] ones_cnt;
  logic [ONES_W-1:0] ones_next;

  // --------------------
  // Synchronizers
  // --------------------

  // Lines idle high
  always_ff @(posedge clk) begin
    if (reset) begin
      clk_meta <= 1'b1;
      clk_sync <= 1'b1;
      clk_prev <= 1'b1;
    end else begin
      clk_meta <= ps2_clk;
      clk_sync <= clk_meta;
      clk_prev <= clk_sync;  // Edge register
    end
  end

  always_ff @(posedge clk) begin
    data_meta <= ps2_data;
    data_sync <= data_meta;
  end

  assign clk_fall  = clk_prev & ~clk_sync;
  assign ones_next = ones_cnt + ONES_W'(data_sync);  // Count including current sample

  // --------------------
  // Majority sampling
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      busy       <= 1'b0;
      step_cnt   <= '0;
      sample_cnt <= '0;
      ones_cnt   <= '0;
      bit_out    <= '0;
    end else begin
      bit_out.valid <= 1'b0;  // Strobe lasts one cycle
      if (clk_fall) begin  // New bit, restart window
        busy       <= 1'b1;
        step_cnt   <= '0;
        sample_cnt <= '0;
        ones_cnt   <= '0;
      end else if (busy) begin
        if (step_cnt == STEP_W'(SAMPLE_STEP - 1)) begin
          step_cnt   <= '0;
          ones_cnt   <= ones_next;
          sample_cnt <= sample_cnt + 1'b1;
          if (sample_cnt == CNT_W'(SAMPLE_COUNT - 1)) begin  // Last sample
            busy          <= 1'b0;
            bit_out.valid <= 1'b1;
            bit_out.value <= (ones_next > ONES_W'(SAMPLE_COUNT / 2));
          end
        end else begin
          step_cnt <= step_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// ==== hdl/ps2_frame_receiver.sv ====
`timescale 1ns/1ps
`include "ps2_display_macros.svh"

module ps2_frame_receiver
  import ps2_display_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      ps2_clk,
  input  logic      ps2_data,
  output logic      byte_req,
  output ps2_byte_t byte_data,
  input  logic      byte_ack
);

  localparam int BIT_CNT_W = $clog2(`PS2_BYTE_W);

  typedef enum logic [1:0] {
    ST_IDLE,    // Waiting for start bit
    ST_DATA,    // Shifting data bits
    ST_PARITY,  // Checking parity bit
    ST_STOP     // Checking stop bit
  } rx_state_t;

  rx_state_t            state;
  ps2_bit_t             rx_bit;
  ps2_byte_t            shift_reg;   // LSB arrives first
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic                 parity_acc;  // XOR of data bits so far
  logic                 parity_ok;

  ps2_bit_sampler ps2_bit_sampler_i (
    .clk      (clk),
    .reset    (reset),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .bit_out  (rx_bit)
  );

  // --------------------
  // Frame FSM
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= ST_IDLE;
      bit_cnt    <= '0;
      parity_acc <= 1'b0;
      parity_ok  <= 1'b0;
      byte_req   <= 1'b0;
    end else begin
      if (byte_req && byte_ack) begin
        byte_req <= 1'b0;  // Second phase of handshake
      end
      if (rx_bit.valid) begin
        case (state)
          ST_IDLE: begin
            if (!rx_bit.value) begin  // Start bit is low
              state      <= ST_DATA;
              bit_cnt    <= '0;
              parity_acc <= 1'b0;
            end
          end
          ST_DATA: begin
            parity_acc <= parity_acc ^ rx_bit.value;
            bit_cnt    <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_CNT_W'(`PS2_BYTE_W - 1)) begin
              state <= ST_PARITY;
            end
          end
          ST_PARITY: begin
            parity_ok <= parity_acc ^ rx_bit.value;  // Odd number of ones overall
            state     <= ST_STOP;  // Stay framed even on bad parity
          end
          ST_STOP: begin
            // Good frame only offered when the handshake is fully idle
            if (rx_bit.value && parity_ok && !byte_req && !byte_ack) begin
              byte_req <= 1'b1;
            end
            state <= ST_IDLE;
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  // Payload path
  always_ff @(posedge clk) begin
    if (rx_bit.valid && state == ST_DATA) begin
      shift_reg <= {rx_bit.value, shift_reg[`PS2_BYTE_W-1:1]};
    end
    // Latched only when a new request goes up
    if (rx_bit.valid && state == ST_STOP && rx_bit.value && parity_ok &&
        !byte_req && !byte_ack) begin
      byte_data <= shift_reg;
    end
  end

endmodule

// ==== hdl/radix_digit_stage.sv ====
`timescale 1ns/1ps
`include "ps2_display_macros.svh"

module radix_digit_stage
  import ps2_display_pkg::*;
(
  input  ps2_byte_t    dividend,
  output digit_stage_t stage_out
);

  localparam int W     = `PS2_BYTE_W;
  localparam int REM_W = W + 1;  // Extra sign bit for the partial remainder
  localparam logic [REM_W-1:0] DIVISOR = REM_W'(`DISP_BASE);

  logic [REM_W-1:0] part_rem [W:0];    // Remainder after each step
  logic [REM_W-1:0] shifted  [W-1:0];  // Remainder with next dividend bit
  logic [W-1:0]     quot;
  logic [REM_W-1:0] final_rem;

  assign part_rem[0] = '0;

  // --------------------
  // Non-restoring steps
  // --------------------

  // MSB of dividend enters first
  for (genvar g = 0; g < W; g++) begin : g_step
    assign shifted[g] = {part_rem[g][REM_W-2:0], dividend[W-1-g]};

    // Negative remainder adds back, positive subtracts
    assign part_rem[g+1] = part_rem[g][REM_W-1] ? shifted[g] + DIVISOR :
                                                  shifted[g] - DIVISOR;

    assign quot[W-1-g] = ~part_rem[g+1][REM_W-1];  // 1 when remainder stays positive
  end

  // Final correction of a negative remainder
  assign final_rem = part_rem[W][REM_W-1] ? part_rem[W] + DIVISOR : part_rem[W];

  assign stage_out.quotient  = quot;
  assign stage_out.remainder = final_rem[$bits(digit_t)-1:0];  // Always below the base

endmodule

// ==== hdl/seg_display_driver.sv ====
`timescale 1ns/1ps
`include "ps2_display_macros.svh"

module seg_display_driver
  import ps2_display_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       byte_req,
  output logic       byte_ack,
  input  digit_vec_t digits,
  output logic       disp_req,
  output seg_vec_t   disp_segs,
  input  logic       disp_ack
);

  typedef enum logic [1:0] {
    ST_IDLE,     // Waiting for a byte
    ST_SHOW,     // disp_req up, waiting for disp_ack
    ST_RELEASE   // byte_ack up, waiting for byte_req to drop
  } drv_state_t;

  drv_state_t state;
  seg_vec_t   seg_next;

  // --------------------
  // Segment lookup
  // --------------------

  // Active-high shapes, inverted on return
  function automatic seg_t seg_encode(input digit_t d);
    seg_t lit;
    case (d)
      4'h0: lit = 7'b0111111;
      4'h1: lit = 7'b0000110;
      4'h2: lit = 7'b1011011;
      4'h3: lit = 7'b1001111;
      4'h4: lit = 7'b1100110;
      4'h5: lit = 7'b1101101;
      4'h6: lit = 7'b1111101;
      4'h7: lit = 7'b0000111;
      4'h8: lit = 7'b1111111;
      4'h9: lit = 7'b1101111;
      4'hA: lit = 7'b1110111;
      4'hB: lit = 7'b1111100;
      4'hC: lit = 7'b0111001;
      4'hD: lit = 7'b1011110;
      4'hE: lit = 7'b1111001;
      default: lit = 7'b1110001;  // F
    endcase
    return ~lit;
  endfunction

  always_comb begin
    for (int i = 0; i < `DISP_DIGITS; i++) begin
      seg_next[i] = seg_encode(digits[i]);
    end
  end

  // --------------------
  // Handshake FSM
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      byte_ack  <= 1'b0;
      disp_req  <= 1'b0;
      disp_segs <= {`DISP_DIGITS{`SEG_BLANK}};
    end else begin
      case (state)
        ST_IDLE: begin
          // Previous display cycle must be fully closed
          if (byte_req && !disp_ack) begin
            disp_segs <= seg_next;  // Digits are stable while byte_req is high
            disp_req  <= 1'b1;
            state     <= ST_SHOW;
          end
        end
        ST_SHOW: begin
          if (disp_ack) begin
            disp_req <= 1'b0;
            byte_ack <= 1'b1;  // Release receiver only after outside took it
            state    <= ST_RELEASE;
          end
        end
        ST_RELEASE: begin
          if (!byte_req) begin
            byte_ack <= 1'b0;
            state    <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== hdl/ps2_digit_display.sv ====
`timescale 1ns/1ps
`include "ps2_display_macros.svh"

module ps2_digit_display
  import ps2_display_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     ps2_clk,
  input  logic     ps2_data,
  output logic     disp_req,
  output seg_vec_t disp_segs,
  input  logic     disp_ack
);

  logic         byte_req;
  logic         byte_ack;
  ps2_byte_t    byte_data;
  ps2_byte_t    stage_in  [`DISP_DIGITS-1:0];  // Dividend of each stage
  digit_stage_t stage_out [`DISP_DIGITS-1:0];
  digit_vec_t   digits;

  // --------------------
  // Receiver
  // --------------------

  ps2_frame_receiver ps2_frame_receiver_i (
    .clk       (clk),
    .reset     (reset),
    .ps2_clk   (ps2_clk),
    .ps2_data  (ps2_data),
    .byte_req  (byte_req),
    .byte_data (byte_data),
    .byte_ack  (byte_ack)
  );

  // --------------------
  // Digit chain
  // --------------------

  assign stage_in[0] = byte_data;

  for (genvar g = 0; g < `DISP_DIGITS; g++) begin : g_digit
    if (g > 0) begin : g_link
      assign stage_in[g] = stage_out[g-1].quotient;  // Quotient feeds next digit
    end

    radix_digit_stage radix_digit_stage_i (
      .dividend  (stage_in[g]),
      .stage_out (stage_out[g])
    );

    assign digits[g] = stage_out[g].remainder;
  end

  seg_display_driver seg_display_driver_i (
    .clk       (clk),
    .reset     (reset),
    .byte_req  (byte_req),
    .byte_ack  (byte_ack),
    .digits    (digits),
    .disp_req  (disp_req),
    .disp_segs (disp_segs),
    .disp_ack  (disp_ack)
  );

endmodule

// ==== verif/ps2_digit_display_asserts.sv ====
`timescale 1ns/1ps

module ps2_digit_display_asserts
  import ps2_display_pkg::*;
(
  input logic     clk,
  input logic     reset,
  input logic     byte_req,
  input logic     byte_ack,
  input logic     disp_req,
  input logic     disp_ack,
  input seg_vec_t disp_segs
);

  int fail_count;  // Failed assertions so far

  // --------------------
  // Display handshake
  // --------------------

  disp_req_held: assert property (@(posedge clk) disable iff (reset)
    disp_req && !disp_ack |=> disp_req)
    else begin
      $error("disp_req dropped before disp_ack");
      fail_count++;
    end

  // Segment codes frozen for the whole request
  disp_segs_stable: assert property (@(posedge clk) disable iff (reset)
    disp_req |=> $stable(disp_segs))
    else begin
      $error("disp_segs changed while disp_req was high");
      fail_count++;
    end

  // New request only after ack has fallen
  disp_req_wait: assert property (@(posedge clk) disable iff (reset)
    !disp_req && disp_ack |=> !disp_req)
    else begin
      $error("disp_req rose while disp_ack was still high");
      fail_count++;
    end

  // --------------------
  // Byte handshake
  // --------------------

  byte_req_held: assert property (@(posedge clk) disable iff (reset)
    byte_req && !byte_ack |=> byte_req)
    else begin
      $error("byte_req dropped before byte_ack");
      fail_count++;
    end

  // Both requests clear right out of reset
  reset_quiet: assert property (@(posedge clk)
    reset |=> !disp_req && !byte_req)
    else begin
      $error("Request high in the cycle after reset");
      fail_count++;
    end

endmodule

bind ps2_digit_display ps2_digit_display_asserts ps2_digit_display_asserts_i (
  .clk       (clk),
  .reset     (reset),
  .byte_req  (byte_req),
  .byte_ack  (byte_ack),
  .disp_req  (disp_req),
  .disp_ack  (disp_ack),
  .disp_segs (disp_segs)
);

// ==== verif/ps2_digit_display_tb.sv ====
`timescale 1ns/1ps
`include "ps2_display_macros.svh"

module ps2_digit_display_tb
  import ps2_display_pkg::*;
();

  localparam int PS2_HALF    = 50;   // System clocks per PS/2 half period
  localparam int REQ_LIMIT   = 500;  // Cycles allowed for disp_req to rise
  localparam int ACK_LIMIT   = 20;   // Cycles allowed per handshake step
  localparam int QUIET_LIMIT = 400;  // Window that must stay free of disp_req

  // Active-low decimal shapes, index is the digit
  localparam seg_t SEG_CODE [10] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
                                     7'h12, 7'h02, 7'h78, 7'h00, 7'h10};

  logic        clk;
  logic        reset;
  logic        ps2_clk;
  logic        ps2_data;
  logic        disp_req;
  seg_vec_t    disp_segs;
  logic        disp_ack;

  ps2_digit_display ps2_digit_display_i (
    .clk       (clk),
    .reset     (reset),
    .ps2_clk   (ps2_clk),
    .ps2_data  (ps2_data),
    .disp_req  (disp_req),
    .disp_segs (disp_segs),
    .disp_ack  (disp_ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // --------------------
  // Model and checks
  // --------------------

  // Ones, tens, hundreds through the shape table
  function automatic seg_vec_t expected_segs(input ps2_byte_t value);
    seg_vec_t exp;
    int       rest;
    rest = value;
    for (int i = 0; i < `DISP_DIGITS; i++) begin
      exp[i] = SEG_CODE[rest % 10];
      rest   = rest / 10;
    end
    return exp;
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_segs(input string name, input seg_vec_t got, input seg_vec_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run("Segment codes do not match the decimal model");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run("Control bit has the wrong level");
    end
  endtask

  // Bound assertion failures end the run at once
  always @(posedge clk) begin
    if (ps2_digit_display_i.ps2_digit_display_asserts_i.fail_count != 0) begin
      abort_run("A bound handshake assertion failed");
    end
  end

  // --------------------
  // Waits
  // --------------------

  task automatic wait_disp_req(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (disp_req !== level) begin
      if (n == limit) abort_run($sformatf("Timeout waiting for %s", what));
      @(posedge clk);
      n++;
    end
  endtask

  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    while (ps2_digit_display_i.byte_req !== 1'b0 || ps2_digit_display_i.byte_ack !== 1'b0) begin
      if (n == limit) abort_run("Timeout waiting for the byte handshake to go idle");
      @(posedge clk);
      n++;
    end
  endtask

  task automatic expect_quiet(input int limit, input string after_what);
    repeat (limit) begin
      @(posedge clk);
      if (disp_req !== 1'b0) abort_run($sformatf("Unexpected disp_req after %s", after_what));
    end
  endtask

  // --------------------
  // Stimulus
  // --------------------

  // Start, 8 data bits LSB first, odd parity, stop
  task automatic send_frame(input ps2_byte_t value, input logic bad_parity,
                            input logic bad_stop);
    logic [10:0] frame;
    frame = {~bad_stop, (~^value) ^ bad_parity, value, 1'b0};
    for (int i = 0; i < 11; i++) begin
      @(posedge clk);
      ps2_data <= frame[i];  // Changes while ps2_clk is high
      repeat (PS2_HALF / 2) @(posedge clk);
      ps2_clk <= 1'b0;
      repeat (PS2_HALF) @(posedge clk);
      ps2_clk <= 1'b1;
      repeat (PS2_HALF / 2 - 1) @(posedge clk);
    end
    @(posedge clk);
    ps2_data <= 1'b1;  // Line idle
  endtask

  task automatic finish_handshake();
    @(posedge clk);
    disp_ack <= 1'b1;
    wait_disp_req(1'b0, ACK_LIMIT, "disp_req to fall");
    @(posedge clk);
    disp_ack <= 1'b0;
    wait_idle(ACK_LIMIT);
  endtask

  // One good frame through to a closed handshake
  task automatic show_byte(input ps2_byte_t value);
    send_frame(value, 1'b0, 1'b0);
    wait_disp_req(1'b1, REQ_LIMIT, "disp_req to rise");
    check_segs("disp_segs", disp_segs, expected_segs(value));
    finish_handshake();
  endtask

  // --------------------
  // Tests
  // --------------------

  task automatic test_reset_state();
    @(posedge clk);
    check_bit("disp_req", disp_req, 1'b0);
    check_segs("disp_segs", disp_segs, {`DISP_DIGITS{`SEG_BLANK}});
  endtask

  task automatic test_good_frame();
    show_byte(8'hF5);  // 245
  endtask

  task automatic test_bad_frames();
    send_frame(8'h3C, 1'b1, 1'b0);  // Parity flipped
    expect_quiet(QUIET_LIMIT, "a bad parity frame");
    send_frame(8'h3C, 1'b0, 1'b1);  // Stop bit low
    expect_quiet(QUIET_LIMIT, "a bad stop frame");
    show_byte(8'h07);
  endtask

  task automatic test_back_pressure();
    send_frame(8'd100, 1'b0, 1'b0);
    wait_disp_req(1'b1, REQ_LIMIT, "disp_req to rise for byte 100");
    check_segs("disp_segs", disp_segs, expected_segs(8'd100));
    send_frame(8'h5A, 1'b0, 1'b0);  // Lands while byte_req is still high
    check_bit("disp_req", disp_req, 1'b1);
    check_segs("disp_segs", disp_segs, expected_segs(8'd100));
    finish_handshake();
    expect_quiet(QUIET_LIMIT, "the frame sent under back-pressure");
  endtask

  task automatic test_random_bytes();
    ps2_byte_t value;
    show_byte(8'd0);
    show_byte(8'd255);
    repeat (18) begin
      value = ps2_byte_t'($urandom());
      show_byte(value);
    end
  endtask

  initial begin
    void'($urandom(72));  // One seed for the whole run
    reset    = 1'b1;
    ps2_clk  = 1'b1;
    ps2_data = 1'b1;
    disp_ack = 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    test_reset_state();
    test_good_frame();
    test_bad_frames();
    test_back_pressure();
    test_random_bytes();

    if (ps2_digit_display_i.ps2_digit_display_asserts_i.fail_count != 0) begin
      abort_run("A bound handshake assertion failed");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

// ==== filelist.f ====
+incdir+include
hdl/ps2_display_pkg.sv
hdl/ps2_bit_sampler.sv
hdl/ps2_frame_receiver.sv
hdl/radix_digit_stage.sv
hdl/seg_display_driver.sv
hdl/ps2_digit_display.sv
verif/ps2_digit_display_asserts.sv
verif/ps2_digit_display_tb.sv
